//--- compile.f
uart_pkg.sv
wb_pkg.sv
uart_rx_sync.sv
uart_rx_channel.sv
uart_rx_regs.sv
uart_rx_top.sv
tb_uart_rx_top.sv

//--- tb_uart_rx_top.sv
`timescale 1ns/1ps

module tb_uart_rx_top;

  import wb_pkg::*;

  localparam int NUM_CH       = 4;
  localparam int CLKS_PER_BIT = 25;
  localparam int CLK_PERIOD   = 100;
  localparam int ACK_LIMIT    = 8;   // cycles to wait for ack
  localparam int POLL_LIMIT   = 150; // status polls before giving up
  localparam int NUM_FRAMES   = 13;  // 4 single + 4 parallel + 1 ferr + 3 overrun + 1 glitch
  localparam longint TIMEOUT_NS = longint'(NUM_FRAMES) * 10 * CLKS_PER_BIT * CLK_PERIOD * 3;

  logic              sys_clk = 1'b0;
  logic              sys_rst_n;
  logic [NUM_CH-1:0] rxd;
  wb_req_t           wb_req;
  wb_rsp_t           wb_rsp;

  int     errors;
  int     checks;
  integer seed;

  uart_rx_top #(
    .NUM_CH       (NUM_CH),
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) UUT (
    .sys_clk      (sys_clk),
    .sys_rst_n    (sys_rst_n),
    .rxd          (rxd),
    .wb_req       (wb_req),
    .wb_rsp       (wb_rsp)
  );

  always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

  function automatic logic [7:0] reg_addr(input int ch, input logic off);
    return 8'(ch * REGS_PER_CH + off);
  endfunction

  // level sits in 5:4 above frame_err in 2, overrun in 1 and valid in 0
  function automatic logic [31:0] status_word(input logic valid, input logic overrun,
                                              input logic ferr, input logic [1:0] level);
    return (32'(level) << 4) | (32'(ferr) << 2) | (32'(overrun) << 1) | 32'(valid);
  endfunction

  task automatic expect_equal(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err_start);
    $display("%s finished with %0d errors", name, errors - err_start);
  endtask

  // one frame on each masked line, with the byte for line i in bits 8i+7:8i
  task automatic uart_send(input logic [NUM_CH-1:0] mask, input logic [31:0] bytes,
                           input logic stop_bit);
    @(posedge sys_clk);
    #1;
    for (int b = 0; b < 10; b++) begin
      for (int ch = 0; ch < NUM_CH; ch++) begin
        if (mask[ch]) begin
          if (b == 0) rxd[ch] = 1'b0;
          else if (b == 9) rxd[ch] = stop_bit;
          else rxd[ch] = bytes[8 * ch + b - 1];
        end
      end
      repeat (CLKS_PER_BIT) @(posedge sys_clk);
      #1;
    end
    rxd = '1; // back to idle
  endtask

  task automatic low_pulse(input logic [NUM_CH-1:0] mask, input int len);
    @(posedge sys_clk);
    #1;
    rxd = ~mask;
    repeat (len) @(posedge sys_clk);
    #1;
    rxd = '1;
  endtask

  task automatic wb_read(input logic [7:0] adr, output logic [31:0] data, output int cycles);
    @(posedge sys_clk);
    #1;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = 1'b0;
    wb_req.adr = adr;
    wb_req.sel = 4'hf;
    @(negedge sys_clk);
    expect_equal("wb_rsp.ack before clock edge", 32'(wb_rsp.ack), 32'h0); // not combinational
    cycles = 0;
    do begin
      @(posedge sys_clk);
      #1;
      cycles++;
    end while (!wb_rsp.ack && cycles < ACK_LIMIT);
    checks++;
    assert (wb_rsp.ack) else begin
      $display("bus read at address %h was never acknowledged", adr);
      errors++;
    end
    data   = wb_rsp.dat_r;
    wb_req = '0;
    @(posedge sys_clk);
    #1;
    expect_equal("wb_rsp.ack after release", 32'(wb_rsp.ack), 32'h0); // single cycle ack
  endtask

  // poll a channel until all bits in mask are set
  task automatic wait_status(input int ch, input logic [31:0] mask);
    logic [31:0] d;
    int          cyc;
    int          polls;
    polls = 0;
    do begin
      wb_read(reg_addr(ch, REG_STATUS), d, cyc);
      polls++;
    end while ((d & mask) != mask && polls < POLL_LIMIT);
    checks++;
    assert ((d & mask) == mask) else begin
      $display("channel %0d status never showed bits %h", ch, mask);
      errors++;
    end
  endtask

  task automatic check_reset_state;
    logic [31:0] d;
    int          cyc;
    int          e0;
    e0 = errors;
    for (int ch = 0; ch < NUM_CH; ch++) begin
      wb_read(reg_addr(ch, REG_STATUS), d, cyc);
      expect_equal($sformatf("dat_r status ch%0d", ch), d, 32'h0);
      expect_equal("ack delay", 32'(cyc), 32'd1);
    end
    wb_read(8'(NUM_CH * REGS_PER_CH), d, cyc); // outside the map
    expect_equal("dat_r unmapped", d, 32'h0);
    expect_equal("ack delay", 32'(cyc), 32'd1);
    report_test("reset state", e0);
  endtask

  task automatic single_frame_each;
    logic [31:0] d;
    logic [7:0]  b;
    int          cyc;
    int          e0;
    e0 = errors;
    for (int ch = 0; ch < NUM_CH; ch++) begin
      b = 8'($random(seed));
      uart_send(NUM_CH'(1 << ch), 32'(b) << (8 * ch), 1'b1);
      wait_status(ch, 32'h1);
      wb_read(reg_addr(ch, REG_STATUS), d, cyc);
      expect_equal($sformatf("dat_r status ch%0d", ch), d, status_word(1, 0, 0, 2'd1));
      wb_read(reg_addr(ch, REG_DATA), d, cyc);
      expect_equal($sformatf("dat_r data ch%0d", ch), d, {24'd0, b});
      wb_read(reg_addr(ch, REG_STATUS), d, cyc);
      expect_equal($sformatf("dat_r status ch%0d", ch), d, 32'h0);
    end
    report_test("single frame per channel", e0);
  endtask

  task automatic all_lines_at_once;
    logic [31:0] d;
    logic [31:0] bytes;
    int          cyc;
    int          e0;
    e0 = errors;
    bytes = $random(seed);
    uart_send('1, bytes, 1'b1);
    for (int ch = 0; ch < NUM_CH; ch++) begin
      wait_status(ch, 32'h1);
      wb_read(reg_addr(ch, REG_DATA), d, cyc);
      expect_equal($sformatf("dat_r data ch%0d", ch), d, {24'd0, bytes[8 * ch +: 8]});
      wb_read(reg_addr(ch, REG_STATUS), d, cyc);
      expect_equal($sformatf("dat_r status ch%0d", ch), d, 32'h0);
    end
    report_test("all lines at once", e0);
  endtask

  task automatic low_stop_bit;
    logic [31:0] d;
    logic [7:0]  b;
    int          cyc;
    int          e0;
    e0 = errors;
    b = 8'($random(seed));
    uart_send(NUM_CH'(2), 32'(b) << 8, 1'b0); // channel 1
    wait_status(1, 32'h1);
    wb_read(reg_addr(1, REG_STATUS), d, cyc);
    expect_equal("dat_r status ch1", d, status_word(1, 0, 1, 2'd1));
    wb_read(reg_addr(1, REG_DATA), d, cyc);
    expect_equal("dat_r data ch1", d, {23'd0, 1'b1, b});
    wb_read(reg_addr(1, REG_STATUS), d, cyc);
    expect_equal("dat_r status ch1", d, 32'h0);
    report_test("frame error", e0);
  endtask

  task automatic overrun_on_third;
    logic [31:0] d;
    logic [7:0]  b [3];
    int          cyc;
    int          e0;
    e0 = errors;
    for (int i = 0; i < 3; i++) begin
      b[i] = 8'($random(seed));
      uart_send(NUM_CH'(8), 32'(b[i]) << 24, 1'b1); // channel 3
    end
    wait_status(3, 32'h2);
    wb_read(reg_addr(3, REG_STATUS), d, cyc);
    expect_equal("dat_r status ch3", d, status_word(1, 1, 0, 2'd2));
    wb_read(reg_addr(3, REG_DATA), d, cyc);
    expect_equal("dat_r data ch3 first", d, {24'd0, b[0]});
    wb_read(reg_addr(3, REG_STATUS), d, cyc);
    expect_equal("dat_r status ch3", d, status_word(1, 0, 0, 2'd1));
    wb_read(reg_addr(3, REG_DATA), d, cyc);
    expect_equal("dat_r data ch3 second", d, {24'd0, b[1]});
    wb_read(reg_addr(3, REG_STATUS), d, cyc);
    expect_equal("dat_r status ch3", d, 32'h0);
    report_test("overrun", e0);
  endtask

  task automatic glitch_rejection;
    logic [31:0] d;
    int          cyc;
    int          e0;
    e0 = errors;
    low_pulse('1, 1);                // below the filter
    low_pulse('1, CLKS_PER_BIT / 3); // gone before mid start bit
    repeat (11 * CLKS_PER_BIT) @(posedge sys_clk); // long enough for a whole frame to land
    for (int ch = 0; ch < NUM_CH; ch++) begin
      wb_read(reg_addr(ch, REG_STATUS), d, cyc);
      expect_equal($sformatf("dat_r status ch%0d", ch), d, 32'h0);
    end
    report_test("glitch rejection", e0);
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("run timed out before the tests finished");
    $display("sim failed");
    $finish;
  end

  initial begin
    errors    = 0;
    checks    = 0;
    seed      = 21;
    sys_rst_n = 1'b0;
    rxd       = '1;
    wb_req    = '0;
    repeat (2) @(posedge sys_clk);
    #1;
    sys_rst_n = 1'b1;

    check_reset_state();
    single_frame_each();
    all_lines_at_once();
    low_stop_bit();
    overrun_on_third();
    glitch_rejection();

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- uart_pkg.sv
package uart_pkg;

  localparam int DATA_BITS        = 8;
  localparam int DEF_CLKS_PER_BIT = 25; // 50 MHz / 2 Mbaud
  localparam int DEF_NUM_CH       = 4;

  // one received byte as it sits in a channel buffer
  typedef struct packed {
    logic [DATA_BITS-1:0] data;
    logic                 frame_err; // stop bit sampled low
  } rx_byte_t;

  // per channel buffer state
  typedef struct packed {
    logic       valid;   // buffer not empty
    logic       overrun; // a byte was dropped
    logic [1:0] level;   // entries held, 0..2
  } rx_status_t;

endpackage

//--- uart_rx_channel.sv
`timescale 1ns/1ps

module uart_rx_channel #(
  parameter int CLKS_PER_BIT = uart_pkg::DEF_CLKS_PER_BIT
) (
  input  logic                  sys_clk,
  input  logic                  sys_rst_n,
  input  logic                  rx_line,
  input  logic                  take,
  output uart_pkg::rx_byte_t    byte_out,
  output uart_pkg::rx_status_t  status
);

  import uart_pkg::*;

  localparam int CNT_W    = $clog2(CLKS_PER_BIT);
  localparam int HALF_BIT = CLKS_PER_BIT / 2;
  localparam int STOP_IDX = DATA_BITS + 1; // start is bit 0

  logic                 rx_last;
  logic                 busy;       // frame in progress
  logic [CNT_W-1:0]     clk_cnt;    // clocks inside current bit
  logic [3:0]           bit_cnt;    // 0 start, 1..8 data, 9 stop
  logic [DATA_BITS-1:0] shreg;
  logic                 fall;
  logic                 mid_bit;
  logic                 push;

  rx_byte_t             mem [2];
  logic                 wr_ptr;
  logic                 rd_ptr;
  logic [1:0]           level;
  logic                 overrun;
  logic                 pop;
  logic                 wr_en;

  assign fall    = rx_last & ~rx_line;
  assign mid_bit = (clk_cnt == CNT_W'(HALF_BIT));
  assign push    = busy & mid_bit & (bit_cnt == 4'(STOP_IDX));

  // bit timing
  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      rx_last <= 1'b1;
      busy    <= 1'b0;
      clk_cnt <= '0;
      bit_cnt <= '0;
    end else begin
      rx_last <= rx_line;
      if (!busy) begin
        if (fall) begin
          busy    <= 1'b1;
          clk_cnt <= '0;
          bit_cnt <= '0;
        end
      end else if (mid_bit && bit_cnt == 4'd0 && rx_line) begin
        busy <= 1'b0; // start bit gone by mid-bit, treat as noise
      end else if (push) begin
        busy <= 1'b0; // done at mid-stop, ready for the next edge
      end else if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
        clk_cnt <= '0;
        bit_cnt <= bit_cnt + 4'd1;
      end else begin
        clk_cnt <= clk_cnt + 1'b1;
      end
    end
  end

  // data bits arrive lsb first
  always_ff @(posedge sys_clk) begin
    if (busy && mid_bit && bit_cnt >= 4'd1 && bit_cnt <= 4'(DATA_BITS)) begin
      shreg <= {rx_line, shreg[DATA_BITS-1:1]};
    end
  end

  // two-entry buffer
  assign pop   = take & (level != 2'd0);
  assign wr_en = push & ((level != 2'd2) | pop); // full but popping still fits

  always_ff @(posedge sys_clk) begin
    if (wr_en) begin
      mem[wr_ptr].data      <= shreg;
      mem[wr_ptr].frame_err <= ~rx_line; // stop bit low
    end
  end

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      wr_ptr  <= 1'b0;
      rd_ptr  <= 1'b0;
      level   <= 2'd0;
      overrun <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr <= ~wr_ptr;
      end
      if (pop) begin
        rd_ptr <= ~rd_ptr;
      end
      case ({wr_en, pop})
        2'b10:   level <= level + 2'd1;
        2'b01:   level <= level - 2'd1;
        default: level <= level;
      endcase
      if (take) begin
        overrun <= 1'b0;
      end else if (push && !wr_en) begin
        overrun <= 1'b1; // byte dropped
      end
    end
  end

  assign byte_out       = (level != 2'd0) ? mem[rd_ptr] : '0;
  assign status.valid   = (level != 2'd0);
  assign status.overrun = overrun;
  assign status.level   = level;

endmodule

//--- uart_rx_regs.sv
`timescale 1ns/1ps

module uart_rx_regs #(
  parameter int NUM_CH = uart_pkg::DEF_NUM_CH
) (
  input  logic                  sys_clk,
  input  logic                  sys_rst_n,
  input  wb_pkg::wb_req_t       wb_req,
  output wb_pkg::wb_rsp_t       wb_rsp,
  input  uart_pkg::rx_byte_t    byte_in [NUM_CH],
  input  uart_pkg::rx_status_t  status  [NUM_CH],
  output logic [NUM_CH-1:0]     take
);

  import uart_pkg::*;
  import wb_pkg::*;

  localparam int CH_W = (NUM_CH > 1) ? $clog2(NUM_CH) : 1;

  logic            req_valid;
  logic            in_map;
  logic            ack_q;
  logic            hit_q;   // read inside the map
  logic [CH_W-1:0] ch_q;
  logic            off_q;
  logic [31:0]     rd_data;
  rx_byte_t        head;
  rx_status_t      stat;

  assign req_valid = wb_req.cyc & wb_req.stb;
  assign in_map    = (wb_req.adr / REGS_PER_CH) < NUM_CH;

  // decode at request, answer one cycle later
  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      ack_q <= 1'b0;
      hit_q <= 1'b0;
      ch_q  <= '0;
      off_q <= 1'b0;
    end else begin
      ack_q <= req_valid & ~ack_q; // one-cycle ack, master drops after it
      hit_q <= req_valid & ~ack_q & ~wb_req.we & in_map; // writes ignored
      ch_q  <= CH_W'(wb_req.adr / REGS_PER_CH);
      off_q <= wb_req.adr[0];
    end
  end

  // read data and pop in the ack cycle itself, so head and pop always
  // refer to the same entry
  assign head = byte_in[ch_q];
  assign stat = status[ch_q];

  always_comb begin
    rd_data = '0;
    take    = '0;
    if (ack_q && hit_q) begin
      if (off_q == REG_DATA) begin
        rd_data = {23'd0, head.frame_err, head.data};
        take[ch_q] = 1'b1;
      end else begin
        rd_data = {26'd0, stat.level, 1'b0, head.frame_err, stat.overrun, stat.valid};
      end
    end
  end

  assign wb_rsp.ack   = ack_q;
  assign wb_rsp.dat_r = rd_data; // zero outside the map

endmodule

//--- uart_rx_sync.sv
`timescale 1ns/1ps

module uart_rx_sync #(
  parameter int NUM_CH = uart_pkg::DEF_NUM_CH
) (
  input  logic              sys_clk,
  input  logic              sys_rst_n,
  input  logic [NUM_CH-1:0] rxd,
  output logic [NUM_CH-1:0] rx_line
);

  logic [NUM_CH-1:0] sync_1;
  logic [NUM_CH-1:0] sync_2;
  logic [NUM_CH-1:0] sync_3;  // previous synchronized sample
  logic [NUM_CH-1:0] held;    // last accepted level

  // all lines idle high out of reset
  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      sync_1 <= '1;
      sync_2 <= '1;
      sync_3 <= '1;
      held   <= '1;
    end else begin
      sync_1 <= rxd;
      sync_2 <= sync_1;
      sync_3 <= sync_2;
      held   <= rx_line;
    end
  end

  // new level only once two consecutive samples agree, so a
  // single-cycle pulse never gets through
  assign rx_line = (sync_2 & sync_3) | (held & (sync_2 ^ sync_3));

endmodule

//--- uart_rx_top.sv
`timescale 1ns/1ps

module uart_rx_top #(
  parameter int NUM_CH       = uart_pkg::DEF_NUM_CH,
  parameter int CLKS_PER_BIT = uart_pkg::DEF_CLKS_PER_BIT
) (
  input  logic              sys_clk,
  input  logic              sys_rst_n,
  input  logic [NUM_CH-1:0] rxd,
  input  wb_pkg::wb_req_t   wb_req,
  output wb_pkg::wb_rsp_t   wb_rsp
);

  import uart_pkg::*;

  logic [NUM_CH-1:0] rx_line;   // conditioned serial lines
  logic [NUM_CH-1:0] take;      // pop strobes from the register block
  rx_byte_t          byte_out [NUM_CH];
  rx_status_t        status   [NUM_CH];

  uart_rx_sync #(
    .NUM_CH    (NUM_CH)
  ) u_sync (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .rxd       (rxd),
    .rx_line   (rx_line)
  );

  // one receiver per line
  for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
    uart_rx_channel #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_channel (
      .sys_clk      (sys_clk),
      .sys_rst_n    (sys_rst_n),
      .rx_line      (rx_line[i]),
      .take         (take[i]),
      .byte_out     (byte_out[i]),
      .status       (status[i])
    );
  end

  uart_rx_regs #(
    .NUM_CH    (NUM_CH)
  ) u_regs (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .byte_in   (byte_out),
    .status    (status),
    .take      (take)
  );

endmodule

//--- wb_pkg.sv
package wb_pkg;

  // classic cycle, master side
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [7:0]  adr;   // word address
    logic [31:0] dat_w;
    logic [3:0]  sel;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat_r;
  } wb_rsp_t;

  // word address = channel * REGS_PER_CH + offset
  localparam int   REGS_PER_CH = 2;
  localparam logic REG_STATUS  = 1'b0;
  localparam logic REG_DATA    = 1'b1;

endpackage
